/* Makefile */
.PHONY: run clean

run: obj_dir/Vtb_osd
	./obj_dir/Vtb_osd | tee sim.log
	grep -q "Simulation PASSED" sim.log

obj_dir/Vtb_osd: list.f osd_consts.svh $(wildcard *.sv)
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_osd -f list.f

clean:
	rm -rf obj_dir sim.log

/* list.f */
+incdir+.
osd_pkg.sv
video_source.sv
osd_window.sv
osd_regs.sv
osd_bitmap.sv
osd_top.sv
tb_osd.sv

/* osd_bitmap.sv */
// Overlay bitmap of one bit per 8x8 block, written by words and read per pixel
`include "osd_consts.svh"

module osd_bitmap
(
  input  logic                  clk_pixel,
  input  logic                  i_wr_en,
  input  logic [6:0]            i_wr_index,
  input  osd_pkg::bitmap_word_t i_wr_data,
  input  osd_pkg::coord_t       i_osd_x,
  input  osd_pkg::coord_t       i_osd_y,
  output logic                  o_bit
);

  localparam int WORD_BITS     = $bits(osd_pkg::bitmap_word_t);
  localparam int WORDS_PER_ROW = `BITMAP_W / WORD_BITS;
  localparam int WORDS         = WORDS_PER_ROW * `BITMAP_H;

  osd_pkg::bitmap_word_t mem [WORDS];

  osd_pkg::coord_t       block_x;
  osd_pkg::coord_t       block_y;
  osd_pkg::coord_t       word_addr;
  logic                  in_range;
  osd_pkg::bitmap_word_t word;

  always_ff @(posedge clk_pixel)
  begin
    if (i_wr_en)
      mem[i_wr_index] <= i_wr_data;
  end

  assign block_x  = i_osd_x >> `BLOCK_SHIFT;
  assign block_y  = i_osd_y >> `BLOCK_SHIFT;
  assign in_range = (block_x < `BITMAP_W) && (block_y < `BITMAP_H);

  // Row-major words, four per bitmap row
  assign word_addr = block_y * osd_pkg::coord_t'(WORDS_PER_ROW) + (block_x >> 4);
  assign word      = mem[word_addr[6:0]];

  // Bit 0 of a word is its leftmost block
  assign o_bit = in_range & word[block_x[3:0]];

endmodule

/* osd_consts.svh */
// Raster timing, bar, bitmap and register map constants, included by the RTL and testbench
`ifndef OSD_CONSTS_SVH
`define OSD_CONSTS_SVH

`define H_ACTIVE 160
`define H_FRONT  8
`define H_SYNC   16
`define H_BACK   16
`define H_TOTAL  (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_ACTIVE 120
`define V_FRONT  2
`define V_SYNC   3
`define V_BACK   5
`define V_TOTAL  (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`define BAR_SHIFT   5
`define BLOCK_SHIFT 3
`define BITMAP_W    64
`define BITMAP_H    32

`define ADDR_X_START     8'h00
`define ADDR_X_STOP      8'h01
`define ADDR_Y_START     8'h02
`define ADDR_Y_STOP      8'h03
`define ADDR_CTRL        8'h04
`define ADDR_FG_RG       8'h05
`define ADDR_FG_B        8'h06
`define ADDR_BITMAP_BASE 8'h80

`endif

/* osd_pkg.sv */
// Shared types for the OSD overlay design, referenced with scoped names
package osd_pkg;

  // One colour channel of a pixel
  typedef logic [7:0] color_t;

  // Screen position or position relative to the OSD window
  typedef logic [9:0] coord_t;

  // Configuration register address
  typedef logic [7:0] reg_addr_t;

  // Configuration register write data
  typedef logic [15:0] reg_data_t;

  // Sixteen bitmap bits, bit 0 is the leftmost block
  typedef logic [15:0] bitmap_word_t;

endpackage

/* osd_regs.sv */
// Configuration registers for the OSD window, with bitmap writes passed to the bitmap memory
`include "osd_consts.svh"

module osd_regs
(
  input  logic                 clk_pixel,
  input  logic                 i_rst,
  input  logic                 i_wr_en,
  input  osd_pkg::reg_addr_t   i_wr_addr,
  input  osd_pkg::reg_data_t   i_wr_data,
  output osd_pkg::coord_t      o_x_start,
  output osd_pkg::coord_t      o_x_stop,
  output osd_pkg::coord_t      o_y_start,
  output osd_pkg::coord_t      o_y_stop,
  output logic                 o_enable,
  output logic                 o_transparency,
  output osd_pkg::color_t      o_fg_r,
  output osd_pkg::color_t      o_fg_g,
  output osd_pkg::color_t      o_fg_b,
  output logic                 o_bm_wr_en,
  output logic [6:0]           o_bm_wr_index,
  output osd_pkg::bitmap_word_t o_bm_wr_data
);

  logic               bm_sel;
  osd_pkg::reg_addr_t bm_offset;

  assign bm_sel    = (i_wr_addr >= `ADDR_BITMAP_BASE);
  assign bm_offset = i_wr_addr - `ADDR_BITMAP_BASE;

  always_ff @(posedge clk_pixel)
  begin
    if (i_rst)
    begin
      o_x_start      <= '0;
      o_x_stop       <= '0;
      o_y_start      <= '0;
      o_y_stop       <= '0;
      o_enable       <= 1'b0;
      o_transparency <= 1'b0;
      o_fg_r         <= '0;
      o_fg_g         <= '0;
      o_fg_b         <= '0;
      o_bm_wr_en     <= 1'b0;
    end
    else
    begin
      o_bm_wr_en <= i_wr_en & bm_sel;
      if (i_wr_en && !bm_sel)
      begin
        case (i_wr_addr)
          `ADDR_X_START: o_x_start <= i_wr_data[9:0];
          `ADDR_X_STOP:  o_x_stop  <= i_wr_data[9:0];
          `ADDR_Y_START: o_y_start <= i_wr_data[9:0];
          `ADDR_Y_STOP:  o_y_stop  <= i_wr_data[9:0];
          `ADDR_CTRL:
          begin
            o_enable       <= i_wr_data[0];
            o_transparency <= i_wr_data[1];
          end
          `ADDR_FG_RG:
          begin
            o_fg_r <= i_wr_data[15:8];
            o_fg_g <= i_wr_data[7:0];
          end
          `ADDR_FG_B:    o_fg_b <= i_wr_data[7:0];
          default:       ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_pixel)
  begin
    if (i_wr_en && bm_sel)
    begin
      o_bm_wr_index <= bm_offset[6:0];
      o_bm_wr_data  <= i_wr_data;
    end
  end

endmodule

/* osd_top.sv */
// Top level of the OSD overlay, joining the video source, window mixer, registers and bitmap
module osd_top
(
  input  logic               clk_pixel,
  input  logic               i_rst,
  input  logic               i_pixel_ena,
  input  logic               i_wr_en,
  input  osd_pkg::reg_addr_t i_wr_addr,
  input  osd_pkg::reg_data_t i_wr_data,
  output osd_pkg::color_t    o_r,
  output osd_pkg::color_t    o_g,
  output osd_pkg::color_t    o_b,
  output logic               o_hsync,
  output logic               o_vsync,
  output logic               o_blank
);

  osd_pkg::color_t       src_r;
  osd_pkg::color_t       src_g;
  osd_pkg::color_t       src_b;
  logic                  src_hsync;
  logic                  src_vsync;
  logic                  src_blank;
  osd_pkg::coord_t       x_start;
  osd_pkg::coord_t       x_stop;
  osd_pkg::coord_t       y_start;
  osd_pkg::coord_t       y_stop;
  logic                  enable;
  logic                  transparency;
  osd_pkg::color_t       fg_r;
  osd_pkg::color_t       fg_g;
  osd_pkg::color_t       fg_b;
  logic                  bm_wr_en;
  logic [6:0]            bm_wr_index;
  osd_pkg::bitmap_word_t bm_wr_data;
  osd_pkg::coord_t       osd_x;
  osd_pkg::coord_t       osd_y;
  logic                  osd_bit;

  video_source u_source
  (
    .clk_pixel   (clk_pixel),
    .i_rst       (i_rst),
    .i_pixel_ena (i_pixel_ena),
    .o_r         (src_r),
    .o_g         (src_g),
    .o_b         (src_b),
    .o_hsync     (src_hsync),
    .o_vsync     (src_vsync),
    .o_blank     (src_blank)
  );

  osd_window u_window
  (
    .clk_pixel      (clk_pixel),
    .i_rst          (i_rst),
    .i_pixel_ena    (i_pixel_ena),
    .i_r            (src_r),
    .i_g            (src_g),
    .i_b            (src_b),
    .i_hsync        (src_hsync),
    .i_vsync        (src_vsync),
    .i_blank        (src_blank),
    .i_x_start      (x_start),
    .i_x_stop       (x_stop),
    .i_y_start      (y_start),
    .i_y_stop       (y_stop),
    .i_enable       (enable),
    .i_transparency (transparency),
    .i_osd_bit      (osd_bit),
    .i_fg_r         (fg_r),
    .i_fg_g         (fg_g),
    .i_fg_b         (fg_b),
    .o_osd_x        (osd_x),
    .o_osd_y        (osd_y),
    .o_r            (o_r),
    .o_g            (o_g),
    .o_b            (o_b),
    .o_hsync        (o_hsync),
    .o_vsync        (o_vsync),
    .o_blank        (o_blank)
  );

  osd_regs u_regs
  (
    .clk_pixel      (clk_pixel),
    .i_rst          (i_rst),
    .i_wr_en        (i_wr_en),
    .i_wr_addr      (i_wr_addr),
    .i_wr_data      (i_wr_data),
    .o_x_start      (x_start),
    .o_x_stop       (x_stop),
    .o_y_start      (y_start),
    .o_y_stop       (y_stop),
    .o_enable       (enable),
    .o_transparency (transparency),
    .o_fg_r         (fg_r),
    .o_fg_g         (fg_g),
    .o_fg_b         (fg_b),
    .o_bm_wr_en     (bm_wr_en),
    .o_bm_wr_index  (bm_wr_index),
    .o_bm_wr_data   (bm_wr_data)
  );

  osd_bitmap u_bitmap
  (
    .clk_pixel  (clk_pixel),
    .i_wr_en    (bm_wr_en),
    .i_wr_index (bm_wr_index),
    .i_wr_data  (bm_wr_data),
    .i_osd_x    (osd_x),
    .i_osd_y    (osd_y),
    .o_bit      (osd_bit)
  );

endmodule

/* osd_window.sv */
// Finds the OSD window in the video stream and mixes the overlay colour into it
module osd_window
(
  input  logic            clk_pixel,
  input  logic            i_rst,
  input  logic            i_pixel_ena,
  input  osd_pkg::color_t i_r,
  input  osd_pkg::color_t i_g,
  input  osd_pkg::color_t i_b,
  input  logic            i_hsync,
  input  logic            i_vsync,
  input  logic            i_blank,
  input  osd_pkg::coord_t i_x_start,
  input  osd_pkg::coord_t i_x_stop,
  input  osd_pkg::coord_t i_y_start,
  input  osd_pkg::coord_t i_y_stop,
  input  logic            i_enable,
  input  logic            i_transparency,
  input  logic            i_osd_bit,
  input  osd_pkg::color_t i_fg_r,
  input  osd_pkg::color_t i_fg_g,
  input  osd_pkg::color_t i_fg_b,
  output osd_pkg::coord_t o_osd_x,
  output osd_pkg::coord_t o_osd_y,
  output osd_pkg::color_t o_r,
  output osd_pkg::color_t o_g,
  output osd_pkg::color_t o_b,
  output logic            o_hsync,
  output logic            o_vsync,
  output logic            o_blank
);

  osd_pkg::coord_t x_cnt;
  osd_pkg::coord_t y_cnt;
  logic            hsync_prev;
  logic            line_active;
  logic            hsync_rise;
  logic            in_window;
  logic            overlay;

  function automatic osd_pkg::color_t mix_channel(input osd_pkg::color_t src,
                                                  input osd_pkg::color_t fg,
                                                  input logic            transparent,
                                                  input logic            apply);
    osd_pkg::color_t blended;
    blended = {fg[7], fg[6:0] | src[7:1]};
    if (!apply)
      return src;
    else if (transparent)
      return blended;
    else
      return fg;
  endfunction

  assign hsync_rise = i_hsync & ~hsync_prev;

  // x_cnt and y_cnt hold the position of the pixel currently on the inputs
  always_ff @(posedge clk_pixel)
  begin
    if (i_rst)
    begin
      hsync_prev  <= 1'b0;
      line_active <= 1'b0;
      x_cnt       <= '0;
      y_cnt       <= '0;
    end
    else if (i_pixel_ena)
    begin
      hsync_prev <= i_hsync;
      if (hsync_rise)
        x_cnt <= '0;
      else if (!i_blank)
        x_cnt <= x_cnt + 1'b1;

      if (i_vsync)
      begin
        y_cnt       <= '0;
        line_active <= 1'b0;
      end
      else if (hsync_rise)
      begin
        // Only lines that carried picture advance the line count
        if (line_active)
          y_cnt <= y_cnt + 1'b1;
        line_active <= 1'b0;
      end
      else if (!i_blank)
      begin
        line_active <= 1'b1;
      end
    end
  end

  assign in_window = !i_blank &&
                     (x_cnt >= i_x_start) && (x_cnt <= i_x_stop) &&
                     (y_cnt >= i_y_start) && (y_cnt <= i_y_stop);

  // The bitmap answers these offsets in the same cycle
  assign o_osd_x = x_cnt - i_x_start;
  assign o_osd_y = y_cnt - i_y_start;

  assign overlay = in_window & i_enable & i_osd_bit;

  always_ff @(posedge clk_pixel)
  begin
    if (i_rst)
    begin
      o_hsync <= 1'b0;
      o_vsync <= 1'b0;
      o_blank <= 1'b1;
    end
    else if (i_pixel_ena)
    begin
      o_hsync <= i_hsync;
      o_vsync <= i_vsync;
      o_blank <= i_blank;
    end
  end

  always_ff @(posedge clk_pixel)
  begin
    if (i_pixel_ena)
    begin
      o_r <= mix_channel(i_r, i_fg_r, i_transparency, overlay);
      o_g <= mix_channel(i_g, i_fg_g, i_transparency, overlay);
      o_b <= mix_channel(i_b, i_fg_b, i_transparency, overlay);
    end
  end

endmodule

/* tb_osd.sv */
// Testbench for the OSD overlay top level, built from list.f and run through the Makefile
`include "osd_consts.svh"

module tb_osd;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CASES      = 8;
  localparam int TIMEOUT_CYCLES = 200000;

  typedef struct packed {
    osd_pkg::coord_t x_start;
    osd_pkg::coord_t x_stop;
    osd_pkg::coord_t y_start;
    osd_pkg::coord_t y_stop;
    logic            enable;
    logic            transparent;
    osd_pkg::color_t fg_r;
    osd_pkg::color_t fg_g;
    osd_pkg::color_t fg_b;
    logic            toggle_ena;
  } osd_case_t;

  logic               clk_pixel   = 1'b0;
  logic               i_rst       = 1'b1;
  logic               i_pixel_ena = 1'b0;
  logic               i_wr_en     = 1'b0;
  osd_pkg::reg_addr_t i_wr_addr   = '0;
  osd_pkg::reg_data_t i_wr_data   = '0;
  osd_pkg::color_t    o_r;
  osd_pkg::color_t    o_g;
  osd_pkg::color_t    o_b;
  logic               o_hsync;
  logic               o_vsync;
  logic               o_blank;

  integer                seed = 69;
  int                    pixel_errors = 0;
  int                    count_errors = 0;
  int                    level_errors = 0;
  bit                    timed_out = 1'b0;
  osd_case_t             cur_case = '0;
  osd_case_t             cases [NUM_CASES];
  osd_pkg::bitmap_word_t bitmap_model [128];

  osd_top dut0
  (
    .clk_pixel   (clk_pixel),
    .i_rst       (i_rst),
    .i_pixel_ena (i_pixel_ena),
    .i_wr_en     (i_wr_en),
    .i_wr_addr   (i_wr_addr),
    .i_wr_data   (i_wr_data),
    .o_r         (o_r),
    .o_g         (o_g),
    .o_b         (o_b),
    .o_hsync     (o_hsync),
    .o_vsync     (o_vsync),
    .o_blank     (o_blank)
  );

  always #2 clk_pixel = ~clk_pixel;

  task automatic check_pixel(input int x, input int y, input string chan,
                             input osd_pkg::color_t got, input osd_pkg::color_t exp);
    if (got !== exp)
    begin
      pixel_errors++;
      $display("** Error @ %0t: pixel (%0d,%0d) %s is %02h, expected %02h",
               $time, x, y, chan, got, exp);
    end
  endtask

  task automatic check_count(input string what, input osd_pkg::coord_t got,
                             input osd_pkg::coord_t exp);
    if (got !== exp)
    begin
      count_errors++;
      $display("** Error @ %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      level_errors++;
      $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Colour of one channel at an active screen position, from the bar and mixing rules
  function automatic osd_pkg::color_t expect_channel(input int x, input int y, input int chan);
    int              bar;
    int              bx;
    int              by;
    logic [6:0]      widx;
    logic [3:0]      bidx;
    logic            hit;
    osd_pkg::color_t src;
    osd_pkg::color_t fg;
    bar = x >> `BAR_SHIFT;
    src = (((bar >> (2 - chan)) & 1) != 0) ? 8'hff : 8'h00;
    case (chan)
      0:       fg = cur_case.fg_r;
      1:       fg = cur_case.fg_g;
      default: fg = cur_case.fg_b;
    endcase
    hit = cur_case.enable &&
          (x >= int'(cur_case.x_start)) && (x <= int'(cur_case.x_stop)) &&
          (y >= int'(cur_case.y_start)) && (y <= int'(cur_case.y_stop));
    if (hit)
    begin
      bx = (x - int'(cur_case.x_start)) >> `BLOCK_SHIFT;
      by = (y - int'(cur_case.y_start)) >> `BLOCK_SHIFT;
      if ((bx < `BITMAP_W) && (by < `BITMAP_H))
      begin
        widx = 7'(by * (`BITMAP_W / 16) + bx / 16);
        bidx = 4'(bx % 16);
        hit  = bitmap_model[widx][bidx];
      end
      else
      begin
        hit = 1'b0;
      end
    end
    if (!hit)
      return src;
    else if (cur_case.transparent)
      return {fg[7], fg[6:0] | src[7:1]};
    else
      return fg;
  endfunction

  task automatic write_reg(input osd_pkg::reg_addr_t addr, input osd_pkg::reg_data_t data);
    @(posedge clk_pixel);
    i_wr_en   <= 1'b1;
    i_wr_addr <= addr;
    i_wr_data <= data;
    @(posedge clk_pixel);
    i_wr_en   <= 1'b0;
  endtask

  // One clock step; fresh tells whether the DUT took a pixel on this edge
  task automatic step_cycle(output logic fresh);
    int rnd;
    @(posedge clk_pixel);
    fresh = i_pixel_ena;
    rnd   = $random(seed);
    if (cur_case.toggle_ena)
      i_pixel_ena <= rnd[0];
    else
      i_pixel_ena <= 1'b1;
    @(negedge clk_pixel);
  endtask

  task automatic load_bitmap();
    int         n;
    int         rnd;
    logic [6:0] idx;
    for (n = 0; n < 128; n++)
    begin
      rnd = $random(seed);
      idx = 7'(n);
      bitmap_model[idx] = rnd[15:0];
      write_reg(osd_pkg::reg_addr_t'(`ADDR_BITMAP_BASE + n), rnd[15:0]);
    end
  endtask

  task automatic build_case_table();
    // x_start, x_stop, y_start, y_stop, enable, transparent, fg r g b, toggling enable
    cases[0] = '{10'd20, 10'd99, 10'd10, 10'd69, 1'b0, 1'b0, 8'h12, 8'h34, 8'h56, 1'b0};
    cases[1] = '{10'd24, 10'd103, 10'd16, 10'd79, 1'b1, 1'b0, 8'h12, 8'ha5, 8'h3c, 1'b0};
    cases[2] = '{10'd24, 10'd103, 10'd16, 10'd79, 1'b1, 1'b1, 8'h80, 8'h01, 8'h7e, 1'b0};
    cases[3] = '{10'd0, 10'd159, 10'd0, 10'd119, 1'b1, 1'b0, 8'h40, 8'hc0, 8'h20, 1'b0};
    // Clipped at the right and bottom edges
    cases[4] = '{10'd120, 10'd500, 10'd100, 10'd300, 1'b1, 1'b1, 8'h0f, 8'h80, 8'h55, 1'b0};
    cases[5] = '{10'd0, 10'd63, 10'd5, 10'd44, 1'b1, 1'b0, 8'hff, 8'h00, 8'h99, 1'b0};
    cases[6] = '{10'd24, 10'd103, 10'd16, 10'd79, 1'b1, 1'b0, 8'h12, 8'ha5, 8'h3c, 1'b1};
    cases[7] = '{10'd24, 10'd103, 10'd16, 10'd79, 1'b1, 1'b1, 8'h80, 8'h01, 8'h7e, 1'b1};
  endtask

  task automatic apply_case();
    write_reg(`ADDR_X_START, osd_pkg::reg_data_t'(cur_case.x_start));
    write_reg(`ADDR_X_STOP, osd_pkg::reg_data_t'(cur_case.x_stop));
    write_reg(`ADDR_Y_START, osd_pkg::reg_data_t'(cur_case.y_start));
    write_reg(`ADDR_Y_STOP, osd_pkg::reg_data_t'(cur_case.y_stop));
    write_reg(`ADDR_CTRL, {14'd0, cur_case.transparent, cur_case.enable});
    write_reg(`ADDR_FG_RG, {cur_case.fg_r, cur_case.fg_g});
    write_reg(`ADDR_FG_B, {8'd0, cur_case.fg_b});
  endtask

  task automatic wait_vsync_fall();
    logic fresh;
    logic prev;
    int   cycles;
    bit   seen;
    prev   = o_vsync;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && !timed_out)
    begin
      step_cycle(fresh);
      cycles++;
      if (prev && !o_vsync)
        seen = 1'b1;
      else if (cycles > TIMEOUT_CYCLES)
      begin
        timed_out = 1'b1;
        $display("Timeout: o_vsync did not fall within %0d cycles", TIMEOUT_CYCLES);
      end
      prev = o_vsync;
    end
  endtask

  // Checks every active pixel from the fall of vsync until it rises again
  task automatic check_frame(input int c);
    logic            fresh;
    logic            hsync_prev;
    bit              line_seen;
    bit              done;
    int              cycles;
    osd_pkg::coord_t x;
    osd_pkg::coord_t y;
    hsync_prev = o_hsync;
    line_seen  = 1'b0;
    done       = 1'b0;
    cycles     = 0;
    x          = '0;
    y          = '0;
    while (!done && !timed_out)
    begin
      step_cycle(fresh);
      cycles++;
      if (cycles > TIMEOUT_CYCLES)
      begin
        timed_out = 1'b1;
        $display("Timeout: the frame of case %0d did not complete", c);
      end
      else if (fresh)
      begin
        if (!o_blank)
        begin
          check_pixel(int'(x), int'(y), "red", o_r, expect_channel(int'(x), int'(y), 0));
          check_pixel(int'(x), int'(y), "green", o_g, expect_channel(int'(x), int'(y), 1));
          check_pixel(int'(x), int'(y), "blue", o_b, expect_channel(int'(x), int'(y), 2));
          x++;
          line_seen = 1'b1;
        end
        if (o_hsync && !hsync_prev && line_seen)
        begin
          check_count("pixels per line", x, osd_pkg::coord_t'(`H_ACTIVE));
          y++;
          x         = '0;
          line_seen = 1'b0;
        end
        if (o_vsync)
        begin
          check_count("lines per frame", y, osd_pkg::coord_t'(`V_ACTIVE));
          done = 1'b1;
        end
        hsync_prev = o_hsync;
      end
    end
  endtask

  initial
  begin
    int c;
    repeat (10) @(posedge clk_pixel);
    i_rst <= 1'b0;
    // The pixel enable is still low, so the outputs keep their reset values
    @(posedge clk_pixel);
    @(negedge clk_pixel);
    check_level("o_blank after reset", o_blank, 1'b1);
    check_level("o_hsync after reset", o_hsync, 1'b0);
    check_level("o_vsync after reset", o_vsync, 1'b0);
    build_case_table();
    load_bitmap();
    for (c = 0; c < NUM_CASES && !timed_out; c++)
    begin
      cur_case = cases[3'(c)];
      apply_case();
      wait_vsync_fall();
      if (!timed_out)
        check_frame(c);
    end
    $display("Error counts: pixel %0d, count %0d, level %0d",
             pixel_errors, count_errors, level_errors);
    if (!timed_out && (pixel_errors + count_errors + level_errors == 0))
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

/* video_source.sv */
// Raster timing generator with a colour-bar test picture, feeding the OSD window
`include "osd_consts.svh"

module video_source
(
  input  logic            clk_pixel,
  input  logic            i_rst,
  input  logic            i_pixel_ena,
  output osd_pkg::color_t o_r,
  output osd_pkg::color_t o_g,
  output osd_pkg::color_t o_b,
  output logic            o_hsync,
  output logic            o_vsync,
  output logic            o_blank
);

  osd_pkg::coord_t h_cnt;
  osd_pkg::coord_t v_cnt;
  osd_pkg::coord_t bar;
  logic            active;
  logic            hsync_next;
  logic            vsync_next;

  always_ff @(posedge clk_pixel)
  begin
    if (i_rst)
    begin
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else if (i_pixel_ena)
    begin
      if (h_cnt == osd_pkg::coord_t'(`H_TOTAL - 1))
      begin
        h_cnt <= '0;
        if (v_cnt == osd_pkg::coord_t'(`V_TOTAL - 1))
          v_cnt <= '0;
        else
          v_cnt <= v_cnt + 1'b1;
      end
      else
      begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // Active pixels come first in each line and each frame, then the porches and sync
  assign active     = (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);
  assign hsync_next = (h_cnt >= (`H_ACTIVE + `H_FRONT)) &&
                      (h_cnt <  (`H_ACTIVE + `H_FRONT + `H_SYNC));
  assign vsync_next = (v_cnt >= (`V_ACTIVE + `V_FRONT)) &&
                      (v_cnt <  (`V_ACTIVE + `V_FRONT + `V_SYNC));
  assign bar        = h_cnt >> `BAR_SHIFT;

  always_ff @(posedge clk_pixel)
  begin
    if (i_rst)
    begin
      o_hsync <= 1'b0;
      o_vsync <= 1'b0;
      o_blank <= 1'b1;
    end
    else if (i_pixel_ena)
    begin
      o_hsync <= hsync_next;
      o_vsync <= vsync_next;
      o_blank <= ~active;
    end
  end

  // Bar index bits select full red, green and blue
  always_ff @(posedge clk_pixel)
  begin
    if (i_pixel_ena)
    begin
      o_r <= (active && bar[2]) ? 8'hff : 8'h00;
      o_g <= (active && bar[1]) ? 8'hff : 8'h00;
      o_b <= (active && bar[0]) ? 8'hff : 8'h00;
    end
  end

endmodule
